// File: design/rw_params.svh
`ifndef RW_PARAMS_SVH
`define RW_PARAMS_SVH

// Power-of-two number of write lanes
`define RW_NUM_LANES 4

// log2 of object width in bytes
`define RW_LOG_RW_WIDTH 3

`define RW_LINE_BITS 512 // Memory line width

// log2 of lane queue depth
`define RW_FIFO_LOG_DEPTH 2

`endif

// File: design/rw_pkg.sv
package rw_pkg;

   typedef enum logic [1:0] {
      TASK_WRITE        = 2'd0,
      TASK_UNDO_RESTORE = 2'd1
   } task_type_e;

   typedef logic [3:0]  thread_id_t;
   typedef logic [5:0]  cq_slot_t;
   typedef logic [31:0] locale_t;
   typedef logic [63:0] object_t;

   // Task as it leaves the dispatcher
   typedef struct packed {
      task_type_e ttype;
      locale_t    locale;
      thread_id_t thread;
      cq_slot_t   cq_slot;
      object_t    object;
   } task_t;

   // Lane queue entry with the type folded into the restore flag
   typedef struct packed {
      locale_t    locale;
      thread_id_t thread;
      cq_slot_t   cq_slot;
      object_t    object;
      logic       restore;
   } wr_entry_t;

endpackage

// File: design/task_dispatch.sv
`timescale 1ns/1ps
`include "rw_params.svh"

module task_dispatch (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     in_valid,
   input  rw_pkg::task_type_e       in_ttype,
   input  rw_pkg::locale_t          in_locale,
   input  rw_pkg::thread_id_t       in_thread,
   input  rw_pkg::cq_slot_t         in_cq_slot,
   input  rw_pkg::object_t          in_object,
   output logic [`RW_NUM_LANES-1:0] lane_valid,
   output rw_pkg::task_t            lane_task
);

   localparam int LANE_BITS = $clog2(`RW_NUM_LANES);

   // Payload is shared and only the addressed lane sees a strobe
   always_ff @(posedge clk) begin
      if (in_valid) begin
         lane_task.ttype   <= in_ttype;
         lane_task.locale  <= in_locale;
         lane_task.thread  <= in_thread;
         lane_task.cq_slot <= in_cq_slot;
         lane_task.object  <= in_object;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         lane_valid <= '0;
      end else begin
         lane_valid <= '0;
         if (in_valid) begin
            lane_valid[in_locale[LANE_BITS-1:0]] <= 1'b1; // Low locale bits pick the lane
         end
      end
   end

endmodule

// File: design/lane_fifo.sv
`timescale 1ns/1ps
`include "rw_params.svh"

module lane_fifo (
   input  logic              clk,
   input  logic              rstn,
   input  logic              push,
   input  rw_pkg::wr_entry_t push_entry,
   input  logic              pop,
   output rw_pkg::wr_entry_t head_entry,
   output logic              empty,
   output logic              full
);

   localparam int LOG_DEPTH = `RW_FIFO_LOG_DEPTH;
   localparam int DEPTH     = 1 << LOG_DEPTH;

   rw_pkg::wr_entry_t mem [DEPTH];

   // Extra pointer bit tells full from empty
   logic [LOG_DEPTH:0] wr_ptr;
   logic [LOG_DEPTH:0] rd_ptr;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[LOG_DEPTH-1:0]] <= push_entry;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
      end
   end

   assign head_entry = mem[rd_ptr[LOG_DEPTH-1:0]]; // No read latency
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[LOG_DEPTH] != rd_ptr[LOG_DEPTH]) &&
                  (wr_ptr[LOG_DEPTH-1:0] == rd_ptr[LOG_DEPTH-1:0]);

endmodule

// File: design/write_lane.sv
`timescale 1ns/1ps
`include "rw_params.svh"

module write_lane (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          task_valid,
   input  rw_pkg::task_t                 task_in,
   input  logic [31:0]                   rw_base,
   input  logic                          pop,
   output logic                          head_valid,
   output logic [31:0]                   head_addr,
   output logic [`RW_LINE_BITS-1:0]      head_data,
   output logic [`RW_LINE_BITS/8-1:0]    head_strb,
   output rw_pkg::thread_id_t            head_thread,
   output rw_pkg::cq_slot_t              head_slot,
   output logic                          head_restore
);

   localparam int OBJ_BYTES  = 1 << `RW_LOG_RW_WIDTH;
   localparam int OBJ_BITS   = OBJ_BYTES * 8;
   localparam int SLICES     = `RW_LINE_BITS / OBJ_BITS;
   localparam int SLICE_BITS = $clog2(SLICES);

   rw_pkg::wr_entry_t push_entry;
   rw_pkg::wr_entry_t head;
   logic              fifo_empty;
   logic              fifo_full;
   logic              push;
   logic [SLICE_BITS-1:0] slice;

   always_comb begin
      push_entry.locale  = task_in.locale;
      push_entry.thread  = task_in.thread;
      push_entry.cq_slot = task_in.cq_slot;
      push_entry.object  = task_in.object;
      push_entry.restore = (task_in.ttype == rw_pkg::TASK_UNDO_RESTORE);
   end

   // A push into a full queue is dropped
   assign push = task_valid & ~fifo_full;

   lane_fifo lane_fifo_inst (
      .clk        (clk),
      .rstn       (rstn),
      .push       (push),
      .push_entry (push_entry),
      .pop        (pop),
      .head_entry (head),
      .empty      (fifo_empty),
      .full       (fifo_full)
   );

   assign head_valid   = ~fifo_empty;
   assign head_thread  = head.thread;
   assign head_slot    = head.cq_slot;
   assign head_restore = head.restore;

   assign slice     = head.locale[SLICE_BITS-1:0]; // Object position inside the line
   assign head_addr = rw_base + (head.locale << `RW_LOG_RW_WIDTH);

   always_comb begin
      head_data = '0;
      head_data[slice*OBJ_BITS +: OBJ_BITS] = head.object;
   end

   always_comb begin
      head_strb = '0;
      head_strb[slice*OBJ_BYTES +: OBJ_BYTES] = '1; // Bytes of the object slice only
   end

endmodule

// File: design/write_drain.sv
`timescale 1ns/1ps
`include "rw_params.svh"

module write_drain (
   input  logic                                           clk,
   input  logic                                           rstn,
   input  logic [`RW_NUM_LANES-1:0]                       head_valid,
   input  logic [`RW_NUM_LANES-1:0][31:0]                 head_addr,
   input  logic [`RW_NUM_LANES-1:0][`RW_LINE_BITS-1:0]    head_data,
   input  logic [`RW_NUM_LANES-1:0][`RW_LINE_BITS/8-1:0]  head_strb,
   input  rw_pkg::thread_id_t [`RW_NUM_LANES-1:0]         head_thread,
   input  rw_pkg::cq_slot_t [`RW_NUM_LANES-1:0]           head_slot,
   input  logic [`RW_NUM_LANES-1:0]                       head_restore,
   input  logic                                           bvalid,
   input  rw_pkg::thread_id_t                             bid,
   output logic [`RW_NUM_LANES-1:0]                       pop,
   output logic                                           wvalid,
   output logic [31:0]                                    waddr,
   output logic [`RW_LINE_BITS-1:0]                       wdata,
   output logic [`RW_LINE_BITS/8-1:0]                     wstrb,
   output rw_pkg::thread_id_t                             wid,
   output logic                                           finish_valid,
   output rw_pkg::cq_slot_t                               finish_slot,
   output logic                                           finish_is_restore,
   output logic                                           unlock_valid,
   output rw_pkg::thread_id_t                             unlock_thread
);

   localparam int NUM_LANES = `RW_NUM_LANES;
   localparam int LANE_BITS = $clog2(NUM_LANES);

   logic [LANE_BITS-1:0] last_grant;
   logic [LANE_BITS-1:0] cand;
   logic [LANE_BITS-1:0] grant_idx;
   logic                 grant_found;

   // Search starts one past the last winner and wraps back to it last
   always_comb begin
      grant_found = 1'b0;
      grant_idx   = last_grant;
      cand        = last_grant;
      for (int i = 1; i <= NUM_LANES; i++) begin
         cand = last_grant + LANE_BITS'(i);
         if (!grant_found && head_valid[cand]) begin
            grant_found = 1'b1;
            grant_idx   = cand;
         end
      end
   end

   always_comb begin
      pop = '0;
      if (grant_found) pop[grant_idx] = 1'b1;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_grant   <= LANE_BITS'(NUM_LANES - 1); // Lane 0 goes first
         wvalid       <= 1'b0;
         finish_valid <= 1'b0;
      end else begin
         wvalid       <= grant_found;
         finish_valid <= grant_found; // Finish rides with the write
         if (grant_found) last_grant <= grant_idx;
      end
   end

   always_ff @(posedge clk) begin
      if (grant_found) begin
         waddr             <= head_addr[grant_idx];
         wdata             <= head_data[grant_idx];
         wstrb             <= head_strb[grant_idx];
         wid               <= head_thread[grant_idx];
         finish_slot       <= head_slot[grant_idx];
         finish_is_restore <= head_restore[grant_idx];
      end
   end

   // Memory ack releases the thread one cycle later
   always_ff @(posedge clk) begin
      if (!rstn) begin
         unlock_valid <= 1'b0;
      end else begin
         unlock_valid <= bvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (bvalid) unlock_thread <= bid;
   end

endmodule

// File: design/rw_unit_top.sv
`timescale 1ns/1ps
`include "rw_params.svh"

module rw_unit_top (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic [31:0]                  rw_base,
   input  logic                         in_valid,
   input  rw_pkg::task_type_e           in_ttype,
   input  rw_pkg::locale_t              in_locale,
   input  rw_pkg::thread_id_t           in_thread,
   input  rw_pkg::cq_slot_t             in_cq_slot,
   input  rw_pkg::object_t              in_object,
   input  logic                         bvalid,
   input  rw_pkg::thread_id_t           bid,
   output logic                         wvalid,
   output logic [31:0]                  waddr,
   output logic [`RW_LINE_BITS-1:0]     wdata,
   output logic [`RW_LINE_BITS/8-1:0]   wstrb,
   output rw_pkg::thread_id_t           wid,
   output logic                         finish_valid,
   output rw_pkg::cq_slot_t             finish_slot,
   output logic                         finish_is_restore,
   output logic                         unlock_valid,
   output rw_pkg::thread_id_t           unlock_thread
);

   localparam int NUM_LANES = `RW_NUM_LANES;

   logic [NUM_LANES-1:0]                      lane_valid;
   rw_pkg::task_t                             lane_task;
   logic [NUM_LANES-1:0]                      pop;
   logic [NUM_LANES-1:0]                      head_valid;
   logic [NUM_LANES-1:0][31:0]                head_addr;
   logic [NUM_LANES-1:0][`RW_LINE_BITS-1:0]   head_data;
   logic [NUM_LANES-1:0][`RW_LINE_BITS/8-1:0] head_strb;
   rw_pkg::thread_id_t [NUM_LANES-1:0]        head_thread;
   rw_pkg::cq_slot_t [NUM_LANES-1:0]          head_slot;
   logic [NUM_LANES-1:0]                      head_restore;

   task_dispatch task_dispatch_inst (
      .clk        (clk),
      .rstn       (rstn),
      .in_valid   (in_valid),
      .in_ttype   (in_ttype),
      .in_locale  (in_locale),
      .in_thread  (in_thread),
      .in_cq_slot (in_cq_slot),
      .in_object  (in_object),
      .lane_valid (lane_valid),
      .lane_task  (lane_task)
   );

   for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
      write_lane write_lane_inst (
         .clk          (clk),
         .rstn         (rstn),
         .task_valid   (lane_valid[g]),
         .task_in      (lane_task),
         .rw_base      (rw_base),
         .pop          (pop[g]),
         .head_valid   (head_valid[g]),
         .head_addr    (head_addr[g]),
         .head_data    (head_data[g]),
         .head_strb    (head_strb[g]),
         .head_thread  (head_thread[g]),
         .head_slot    (head_slot[g]),
         .head_restore (head_restore[g])
      );
   end

   write_drain write_drain_inst (
      .clk               (clk),
      .rstn              (rstn),
      .head_valid        (head_valid),
      .head_addr         (head_addr),
      .head_data         (head_data),
      .head_strb         (head_strb),
      .head_thread       (head_thread),
      .head_slot         (head_slot),
      .head_restore      (head_restore),
      .bvalid            (bvalid),
      .bid               (bid),
      .pop               (pop),
      .wvalid            (wvalid),
      .waddr             (waddr),
      .wdata             (wdata),
      .wstrb             (wstrb),
      .wid               (wid),
      .finish_valid      (finish_valid),
      .finish_slot       (finish_slot),
      .finish_is_restore (finish_is_restore),
      .unlock_valid      (unlock_valid),
      .unlock_thread     (unlock_thread)
   );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 10 ns period
   end

   initial begin
      rstn = 1'b0;
      repeat (5) @(posedge clk);
      #1 rstn = 1'b1;
   end

endmodule

// File: test/rw_checker.sv
`timescale 1ns/1ps
`include "rw_params.svh"

module rw_checker (
   input  logic                       clk,
   input  logic                       rstn,
   input  logic [31:0]                rw_base,
   input  logic                       in_valid,
   input  rw_pkg::task_type_e         in_ttype,
   input  rw_pkg::locale_t            in_locale,
   input  rw_pkg::thread_id_t         in_thread,
   input  rw_pkg::cq_slot_t           in_cq_slot,
   input  rw_pkg::object_t            in_object,
   input  logic                       bvalid,
   input  rw_pkg::thread_id_t         bid,
   input  logic                       wvalid,
   input  logic [31:0]                waddr,
   input  logic [`RW_LINE_BITS-1:0]   wdata,
   input  logic [`RW_LINE_BITS/8-1:0] wstrb,
   input  rw_pkg::thread_id_t         wid,
   input  logic                       finish_valid,
   input  rw_pkg::cq_slot_t           finish_slot,
   input  logic                       finish_is_restore,
   input  logic                       unlock_valid,
   input  rw_pkg::thread_id_t         unlock_thread,
   input  logic                       test_done,
   output int                         mismatch_count,
   output int                         other_count,
   output int                         pending_count
);

   localparam int LANE_BITS = $clog2(`RW_NUM_LANES);
   localparam int OBJ_BITS  = 8 << `RW_LOG_RW_WIDTH;
   localparam int SLICES    = `RW_LINE_BITS / OBJ_BITS;

   typedef struct {
      logic [31:0]                addr;
      logic [`RW_LINE_BITS-1:0]   data;
      logic [`RW_LINE_BITS/8-1:0] strb;
      rw_pkg::thread_id_t         thread;
      rw_pkg::cq_slot_t           slot;
      logic                       restore;
      int                         lane;
      int                         in_cycle;
      bit                         lone;    // Unit was empty when it arrived
   } expect_t;

   expect_t            exp_q[$];
   int                 cyc = 0;
   bit                 task_seen = 1'b0;
   bit                 leftovers_done = 1'b0;
   logic               last_bvalid = 1'b0;
   rw_pkg::thread_id_t last_bid = '0;

   initial begin
      mismatch_count = 0;
      other_count    = 0;
      pending_count  = 0;
   end

   task automatic mismatch(input string msg);
      mismatch_count++;
      $display("Mismatch at %0d ns: %s", $time, msg);
   endtask

   task automatic add_expect();
      expect_t                    e;
      int                         slice;
      logic [`RW_LINE_BITS-1:0]   data_w;
      logic [`RW_LINE_BITS/8-1:0] strb_w;
      slice  = int'(in_locale % SLICES);
      data_w = '0;
      data_w[OBJ_BITS-1:0] = in_object;
      strb_w = '0;
      strb_w[OBJ_BITS/8-1:0] = '1;
      e.addr     = rw_base + in_locale * (OBJ_BITS / 8);
      e.data     = data_w << (slice * OBJ_BITS);
      e.strb     = strb_w << (slice * OBJ_BITS / 8);
      e.thread   = in_thread;
      e.slot     = in_cq_slot;
      e.restore  = (in_ttype == rw_pkg::TASK_UNDO_RESTORE);
      e.lane     = int'(in_locale[LANE_BITS-1:0]);
      e.in_cycle = cyc;
      e.lone     = (exp_q.size() == 0);
      exp_q.push_back(e);
   endtask

   task automatic check_write();
      expect_t     e;
      logic [31:0] loc;
      int          lane;
      int          idx;
      loc  = (waddr - rw_base) / (OBJ_BITS / 8);
      lane = int'(loc % `RW_NUM_LANES);
      idx  = -1;
      // Oldest pending task of that lane
      for (int i = exp_q.size() - 1; i >= 0; i--) begin
         if (exp_q[i].lane == lane) idx = i;
      end
      if (idx < 0) begin
         other_count++;
         $display("Write to address %h at %0d ns has no pending task in lane %0d",
                  waddr, $time, lane);
      end else begin
         e = exp_q[idx];
         exp_q.delete(idx);
         if (waddr !== e.addr) mismatch($sformatf("waddr %h, expected %h", waddr, e.addr));
         if (wdata !== e.data) mismatch($sformatf("wdata wrong for address %h", e.addr));
         if (wstrb !== e.strb) mismatch($sformatf("wstrb %h, expected %h", wstrb, e.strb));
         if (wid !== e.thread) mismatch($sformatf("wid %0d, expected %0d", wid, e.thread));
         if (finish_slot !== e.slot) begin
            mismatch($sformatf("finish_slot %0d, expected %0d", finish_slot, e.slot));
         end
         if (finish_is_restore !== e.restore) begin
            mismatch($sformatf("finish_is_restore %b for slot %0d", finish_is_restore, e.slot));
         end
         if (e.lone && (cyc - e.in_cycle) != 3) begin
            mismatch($sformatf("lone task slot %0d took %0d cycles", e.slot, cyc - e.in_cycle));
         end
      end
   endtask

   always @(posedge clk) begin
      if (cyc > 0) begin
         if (!task_seen && (wvalid !== 1'b0 || finish_valid !== 1'b0 ||
                            unlock_valid !== 1'b0)) begin
            mismatch("output strobe high before any task was sent");
         end
         if (wvalid !== finish_valid) begin
            mismatch($sformatf("finish_valid %b with wvalid %b", finish_valid, wvalid));
         end
         if (unlock_valid !== last_bvalid) begin
            mismatch($sformatf("unlock_valid %b one cycle after bvalid %b",
                               unlock_valid, last_bvalid));
         end else if (last_bvalid && unlock_thread !== last_bid) begin
            mismatch($sformatf("unlock_thread %0d, expected %0d", unlock_thread, last_bid));
         end
      end
      if (wvalid === 1'b1) check_write();
      if (rstn === 1'b1 && in_valid === 1'b1) begin
         task_seen = 1'b1;
         add_expect();
      end
      if (test_done === 1'b1 && !leftovers_done) begin
         leftovers_done = 1'b1;
         foreach (exp_q[i]) begin
            other_count++;
            $display("Task for commit slot %0d in lane %0d never produced a write",
                     exp_q[i].slot, exp_q[i].lane);
         end
      end
      last_bvalid   = bvalid;
      last_bid      = bid;
      pending_count = exp_q.size();
      cyc++;
   end

endmodule

// File: test/rw_tb.sv
`timescale 1ns/1ps
`include "rw_params.svh"

module rw_tb;

   typedef struct {
      rw_pkg::task_type_e ttype;
      rw_pkg::locale_t    locale;
      rw_pkg::thread_id_t thread;
      rw_pkg::cq_slot_t   slot;
      rw_pkg::object_t    object;
      int                 gap;     // Idle cycles after the task
   } row_t;

   logic                       clk;
   logic                       rstn;
   logic [31:0]                rw_base;
   logic                       in_valid;
   rw_pkg::task_type_e         in_ttype;
   rw_pkg::locale_t            in_locale;
   rw_pkg::thread_id_t         in_thread;
   rw_pkg::cq_slot_t           in_cq_slot;
   rw_pkg::object_t            in_object;
   logic                       bvalid = 1'b0;
   rw_pkg::thread_id_t         bid = '0;
   logic                       wvalid;
   logic [31:0]                waddr;
   logic [`RW_LINE_BITS-1:0]   wdata;
   logic [`RW_LINE_BITS/8-1:0] wstrb;
   rw_pkg::thread_id_t         wid;
   logic                       finish_valid;
   rw_pkg::cq_slot_t           finish_slot;
   logic                       finish_is_restore;
   logic                       unlock_valid;
   rw_pkg::thread_id_t         unlock_thread;
   logic                       test_done;
   int                         mismatch_count;
   int                         other_count;
   int                         pending_count;

   row_t               rows[$];
   bit                 table_built = 1'b0;
   logic [1:0]         ack_pipe = '0;
   rw_pkg::thread_id_t ack_id [2];

   tb_clock tb_clock_inst (
      .clk  (clk),
      .rstn (rstn)
   );

   rw_unit_top rw_unit_top_inst (
      .clk (clk), .rstn (rstn), .rw_base (rw_base),
      .in_valid (in_valid), .in_ttype (in_ttype), .in_locale (in_locale),
      .in_thread (in_thread), .in_cq_slot (in_cq_slot), .in_object (in_object),
      .bvalid (bvalid), .bid (bid),
      .wvalid (wvalid), .waddr (waddr), .wdata (wdata), .wstrb (wstrb), .wid (wid),
      .finish_valid (finish_valid), .finish_slot (finish_slot),
      .finish_is_restore (finish_is_restore),
      .unlock_valid (unlock_valid), .unlock_thread (unlock_thread)
   );

   rw_checker rw_checker_inst (
      .clk (clk), .rstn (rstn), .rw_base (rw_base),
      .in_valid (in_valid), .in_ttype (in_ttype), .in_locale (in_locale),
      .in_thread (in_thread), .in_cq_slot (in_cq_slot), .in_object (in_object),
      .bvalid (bvalid), .bid (bid),
      .wvalid (wvalid), .waddr (waddr), .wdata (wdata), .wstrb (wstrb), .wid (wid),
      .finish_valid (finish_valid), .finish_slot (finish_slot),
      .finish_is_restore (finish_is_restore),
      .unlock_valid (unlock_valid), .unlock_thread (unlock_thread),
      .test_done (test_done), .mismatch_count (mismatch_count),
      .other_count (other_count), .pending_count (pending_count)
   );

   task automatic add_row(input rw_pkg::task_type_e ttype, input logic [31:0] locale,
                          input logic [3:0] thread, input logic [5:0] slot, input int gap);
      row_t r;
      r.ttype  = ttype;
      r.locale = locale;
      r.thread = thread;
      r.slot   = slot;
      r.object = {$urandom, $urandom};
      r.gap    = gap;
      rows.push_back(r);
   endtask

   task automatic build_table();
      // Lone tasks on an idle unit
      add_row(rw_pkg::TASK_WRITE,        32'h0000_0000, 4'd1,  6'd0,  8);
      add_row(rw_pkg::TASK_UNDO_RESTORE, 32'h0000_001d, 4'd2,  6'd1,  8);
      // Back to back over every lane and slice
      add_row(rw_pkg::TASK_WRITE,        32'h0000_0100, 4'd3,  6'd2,  0);
      add_row(rw_pkg::TASK_UNDO_RESTORE, 32'h0000_0101, 4'd4,  6'd3,  0);
      add_row(rw_pkg::TASK_WRITE,        32'h0000_0102, 4'd5,  6'd4,  0);
      add_row(rw_pkg::TASK_UNDO_RESTORE, 32'h0000_0103, 4'd6,  6'd5,  0);
      add_row(rw_pkg::TASK_WRITE,        32'h0000_0104, 4'd7,  6'd6,  0);
      add_row(rw_pkg::TASK_WRITE,        32'h0000_0105, 4'd8,  6'd7,  0);
      add_row(rw_pkg::TASK_UNDO_RESTORE, 32'h0000_0106, 4'd9,  6'd8,  0);
      add_row(rw_pkg::TASK_WRITE,        32'h0000_0107, 4'd10, 6'd9,  6);
      // Four tasks in lane 0 that keep their order
      add_row(rw_pkg::TASK_WRITE,        32'h0000_0024, 4'd11, 6'd10, 0);
      add_row(rw_pkg::TASK_UNDO_RESTORE, 32'h0000_0028, 4'd12, 6'd11, 0);
      add_row(rw_pkg::TASK_WRITE,        32'h0000_002c, 4'd13, 6'd12, 0);
      add_row(rw_pkg::TASK_WRITE,        32'h0000_0030, 4'd14, 6'd13, 6);
      add_row(rw_pkg::TASK_UNDO_RESTORE, 32'h0fff_fff3, 4'd15, 6'd14, 4); // Top of range
      add_row(rw_pkg::TASK_WRITE,        32'h0000_0055, 4'd0,  6'd15, 0);
      add_row(rw_pkg::TASK_WRITE,        32'h0000_0056, 4'd1,  6'd16, 0);
      add_row(rw_pkg::TASK_UNDO_RESTORE, 32'h0000_0059, 4'd2,  6'd17, 0);
      add_row(rw_pkg::TASK_WRITE,        32'h0000_005f, 4'd3,  6'd18, 1);
      add_row(rw_pkg::TASK_WRITE,        32'h0000_0061, 4'd4,  6'd19, 2);
   endtask

   task automatic drive_row(input row_t r);
      in_valid   = 1'b1;
      in_ttype   = r.ttype;
      in_locale  = r.locale;
      in_thread  = r.thread;
      in_cq_slot = r.slot;
      in_object  = r.object;
      @(posedge clk);
      #1;
      in_valid = 1'b0;
      repeat (r.gap) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Memory answers each write two cycles later
   always @(posedge clk) begin
      ack_pipe  = {ack_pipe[0], wvalid === 1'b1};
      ack_id[1] = ack_id[0];
      ack_id[0] = wid;
      #1;
      bvalid = ack_pipe[1];
      bid    = ack_id[1];
   end

   initial begin
      int seed_ret;
      rw_base    = 32'h8000_0000;
      in_valid   = 1'b0;
      in_ttype   = rw_pkg::TASK_WRITE;
      in_locale  = '0;
      in_thread  = '0;
      in_cq_slot = '0;
      in_object  = '0;
      test_done  = 1'b0;
      seed_ret   = $urandom(32'hfb0f_3f69);
      build_table();
      table_built = 1'b1;
      wait (rstn === 1'b1);
      @(posedge clk);
      #1;
      foreach (rows[i]) begin
         drive_row(rows[i]);
      end
      repeat (2) @(posedge clk);
      wait (pending_count == 0);
      repeat (6) @(posedge clk); // Last acks and unlocks
      #1;
      test_done = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial begin
      wait (table_built);
      repeat (rows.size() * 20 + 200) @(posedge clk);
      $display("Timeout: the DUT did not finish all tasks in time");
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count + 1);
      $display("Result: FAILED");
      $finish;
   end

endmodule

// File: project.f
+incdir+design
design/rw_pkg.sv
design/task_dispatch.sv
design/lane_fifo.sv
design/write_lane.sv
design/write_drain.sv
design/rw_unit_top.sv
test/tb_clock.sv
test/rw_checker.sv
test/rw_tb.sv
